// File: lsq.f
src/lsq_pkg.sv
src/store_queue.sv
src/load_buffer.sv
src/load_order_check.sv
src/store_forward.sv
src/lsq_top.sv
tb/lsq_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsq_tb
FILELIST  ?= lsq.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/lsq_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lsq_tb;

    import lsq_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;
    localparam logic [31:0] LFSR_SEED = 32'd23;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic clock, reset;
    logic store_alloc, store_resolve_valid, store_retire;
    logic [SQ_IDX_W-1:0] store_resolve_idx;
    logic [XLEN-1:0] store_base, store_offset, store_value;
    logic [ROB_IDX_W-1:0] store_rob_idx;
    logic sq_full, sq_head_resolved, store_req_valid;
    logic [SQ_IDX_W-1:0] sq_tail;
    logic [XLEN-1:0] store_req_addr, store_req_data;
    logic load_alloc, load_resolve_valid;
    logic [LB_IDX_W-1:0] load_resolve_idx, lb_free_idx;
    logic [XLEN-1:0] load_base, load_offset;
    logic [PREG_IDX_W-1:0] load_dest_preg, cdb_preg, load_req_preg;
    logic [ROB_IDX_W-1:0] load_rob_idx, cdb_rob_idx, load_req_rob_idx;
    logic lb_full, cdb_valid, load_req_valid;
    logic [XLEN-1:0] cdb_value, load_req_addr;

    // Reference model of the queue
    logic [31:0] m_addr [8];
    logic [31:0] m_data [8];
    logic        m_resolved [8];
    int          m_head, m_tail;
    logic        m_lb_busy [4];
    int          m_lb_age [4];
    logic [31:0] m_lb_addr [4];
    logic [5:0]  m_lb_preg [4];
    logic [4:0]  m_lb_rob [4];
    logic [31:0] lfsr;

    // Expected results
    logic exp_armed, exp_fwd, exp_store;
    logic [31:0] exp_value, exp_addr, exp_store_addr, exp_store_data;
    logic [5:0] exp_preg;
    logic [4:0] exp_rob;

    lsq_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        abort_run("Run stopped at a wrong value");
    endtask

    ////////////////////////////////////////
    // Output checks
    ////////////////////////////////////////

    assert property (@(posedge clock) disable iff (reset) !(cdb_valid && load_req_valid))
        else value_error("CDB and cache load request high together");
    assert property (@(posedge clock) disable iff (reset)
        !cdb_valid || (exp_armed && exp_fwd && cdb_value == exp_value
                       && cdb_preg == exp_preg && cdb_rob_idx == exp_rob))
        else value_error("unexpected or wrong CDB result");
    assert property (@(posedge clock) disable iff (reset)
        !load_req_valid || (exp_armed && !exp_fwd && load_req_addr == exp_addr
                            && load_req_preg == exp_preg && load_req_rob_idx == exp_rob))
        else value_error("unexpected or wrong cache load request");
    assert property (@(posedge clock) disable iff (reset)
        store_req_valid == exp_store && (!exp_store || (store_req_addr == exp_store_addr
                                                       && store_req_data == exp_store_data)))
        else value_error("store request missing, unexpected or wrong");

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic int lowest_free();
        for (int j = 0; j < 4; j++) begin
            if (!m_lb_busy[j]) begin
                return j;
            end
        end
        return 0;
    endfunction

    // Youngest resolved store from head up to the load's age with the same address
    function automatic logic find_forward(input logic [31:0] addr, input int age,
                                          output logic [31:0] value);
        int   pos;
        logic hit;
        hit = 1'b0;
        value = '0;
        pos = m_head;
        while (pos != age) begin
            if (m_resolved[pos] && m_addr[pos] == addr) begin
                hit = 1'b1;
                value = m_data[pos];
            end
            pos = (pos + 1) % 8;
        end
        return hit;
    endfunction

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    task automatic alloc_load(output int slot);
        @(negedge clock);
        assert (!lb_full && lb_free_idx == LB_IDX_W'(lowest_free()))
            else value_error("lb_free_idx is not the lowest free slot");
        slot = lowest_free();
        m_lb_busy[slot] = 1'b1;
        m_lb_age[slot] = m_tail;
        @(posedge clock);
        load_alloc <= 1'b1;
        @(posedge clock);
        load_alloc <= 1'b0;
    endtask

    task automatic arm_load(input int slot);
        logic [31:0] v;
        logic        h;
        h = find_forward(m_lb_addr[slot], m_lb_age[slot], v);
        exp_fwd <= h;
        exp_value <= v;
        exp_addr <= m_lb_addr[slot];
        exp_preg <= m_lb_preg[slot];
        exp_rob <= m_lb_rob[slot];
        exp_armed <= 1'b1;
    endtask

    task automatic resolve_load(input int slot, input logic [31:0] base, input logic [31:0] off,
                                input logic arm);
        m_lb_addr[slot] = base + off;
        m_lb_preg[slot] = random_bits(6);
        m_lb_rob[slot] = random_bits(5);
        @(posedge clock);
        if (arm) begin
            arm_load(slot);
        end
        load_resolve_valid <= 1'b1;
        load_resolve_idx <= LB_IDX_W'(slot);
        load_base <= base;
        load_offset <= off;
        load_dest_preg <= m_lb_preg[slot];
        load_rob_idx <= m_lb_rob[slot];
        @(posedge clock);
        load_resolve_valid <= 1'b0;
    endtask

    // Counts edges from the resolving drive until the load result shows
    task automatic wait_output(input int slot);
        int n;
        n = 1;
        @(negedge clock);
        while (!(cdb_valid || load_req_valid)) begin
            if (n >= TIMEOUT_CYCLES) begin
                abort_run("Timed out waiting for a load result");
            end
            @(posedge clock);
            n++;
            @(negedge clock);
        end
        assert (n == 2) else value_error("load result came at the wrong edge");
        m_lb_busy[slot] = 1'b0;
        assert (lb_free_idx == LB_IDX_W'(lowest_free()))
            else value_error("issued slot not freed");
        @(posedge clock);
        exp_armed <= 1'b0;
    endtask

    task automatic alloc_store();
        @(negedge clock);
        assert (sq_tail == SQ_IDX_W'(m_tail) && sq_full == (((m_tail - m_head) & 7) == 7))
            else value_error("sq_tail or sq_full wrong");
        @(posedge clock);
        store_alloc <= 1'b1;
        @(posedge clock);
        store_alloc <= 1'b0;
        m_tail = (m_tail + 1) % 8;
    endtask

    task automatic resolve_store(input int idx, input logic [31:0] base,
                                 input logic [31:0] off, input logic [31:0] data);
        m_addr[idx] = base + off;
        m_data[idx] = data;
        m_resolved[idx] = 1'b1;
        @(posedge clock);
        store_resolve_valid <= 1'b1;
        store_resolve_idx <= SQ_IDX_W'(idx);
        store_base <= base;
        store_offset <= off;
        store_value <= data;
        store_rob_idx <= random_bits(5);
        @(posedge clock);
        store_resolve_valid <= 1'b0;
    endtask

    task automatic retire_store(input logic honoured);
        @(negedge clock);
        assert (sq_head_resolved == honoured) else value_error("sq_head_resolved wrong");
        @(posedge clock);
        store_retire <= 1'b1;
        exp_store <= honoured;
        exp_store_addr <= m_addr[m_head];
        exp_store_data <= m_data[m_head];
        @(posedge clock);
        store_retire <= 1'b0;
        exp_store <= 1'b0;
        if (honoured) begin
            m_resolved[m_head] = 1'b0;
            m_head = (m_head + 1) % 8;
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int          slot;
        logic [31:0] addr_a;
        {store_alloc, store_resolve_valid, store_retire, load_alloc, load_resolve_valid} = '0;
        {store_resolve_idx, store_base, store_offset, store_value, store_rob_idx} = '0;
        {load_resolve_idx, load_base, load_offset, load_dest_preg, load_rob_idx} = '0;
        {exp_armed, exp_fwd, exp_store, exp_value, exp_addr, exp_preg, exp_rob} = '0;
        {exp_store_addr, exp_store_data} = '0;
        lfsr = LFSR_SEED;
        m_head = 0;
        m_tail = 0;
        for (int i = 0; i < 8; i++) begin
            m_resolved[i] = 1'b0;
        end
        for (int j = 0; j < 4; j++) begin
            m_lb_busy[j] = 1'b0;
        end
        reset = 1'b1;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (!cdb_valid && !load_req_valid && !store_req_valid && !lb_full && !sq_full
                && !sq_head_resolved && sq_tail == 0 && lb_free_idx == 0)
            else value_error("outputs wrong after reset");

        // Fill the load buffer, then drain it through the cache path
        for (int i = 0; i < 4; i++) begin
            alloc_load(slot);
        end
        @(negedge clock);
        assert (lb_full) else value_error("lb_full low with four loads");
        foreach (m_lb_age[j]) begin
            slot = (j + 2) % 4;
            resolve_load(slot, random_bits(32), random_bits(12), 1'b1);
            wait_output(slot);
        end

        // Fill the store queue, retire on an unresolved head is ignored
        for (int i = 0; i < 7; i++) begin
            alloc_store();
        end
        @(negedge clock);
        assert (sq_full) else value_error("sq_full low with seven stores");
        retire_store(1'b0);
        addr_a = random_bits(32);
        for (int i = 0; i < 7; i++) begin
            if (i == 3 || i == 5) begin
                resolve_store(i, addr_a, 0, random_bits(32));
            end else begin
                resolve_store(i, random_bits(32), random_bits(12), random_bits(32));
            end
        end
        alloc_load(slot);
        resolve_load(slot, addr_a, 0, 1'b1);
        wait_output(slot);
        for (int i = 0; i < 7; i++) begin
            retire_store(1'b1);
        end

        // Tail wraps, load waits behind a pending store with a younger match
        addr_a = random_bits(32);
        alloc_store();
        alloc_store();
        resolve_store(7, addr_a, 0, random_bits(32));
        alloc_load(slot);
        alloc_store();
        resolve_store(1, addr_a, 0, random_bits(32));
        resolve_load(slot, addr_a, 0, 1'b0);
        repeat (4) @(posedge clock);
        resolve_store(0, random_bits(32), 32'd4, random_bits(32));
        arm_load(slot);
        wait_output(slot);
        for (int i = 0; i < 3; i++) begin
            retire_store(1'b1);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/lsq_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsq_top (
    input  logic                           clock,
    input  logic                           reset,
    // Store side
    input  logic                           store_alloc,
    input  logic                           store_resolve_valid,
    input  logic [lsq_pkg::SQ_IDX_W-1:0]   store_resolve_idx,
    input  logic [lsq_pkg::XLEN-1:0]       store_base,
    input  logic [lsq_pkg::XLEN-1:0]       store_offset,
    input  logic [lsq_pkg::XLEN-1:0]       store_value,
    input  logic [lsq_pkg::ROB_IDX_W-1:0]  store_rob_idx,
    input  logic                           store_retire,
    output logic                           sq_full,
    output logic                           sq_head_resolved,
    output logic [lsq_pkg::SQ_IDX_W-1:0]   sq_tail,
    output logic                           store_req_valid,
    output logic [lsq_pkg::XLEN-1:0]       store_req_addr,
    output logic [lsq_pkg::XLEN-1:0]       store_req_data,
    // Load side
    input  logic                           load_alloc,
    input  logic                           load_resolve_valid,
    input  logic [lsq_pkg::LB_IDX_W-1:0]   load_resolve_idx,
    input  logic [lsq_pkg::XLEN-1:0]       load_base,
    input  logic [lsq_pkg::XLEN-1:0]       load_offset,
    input  logic [lsq_pkg::PREG_IDX_W-1:0] load_dest_preg,
    input  logic [lsq_pkg::ROB_IDX_W-1:0]  load_rob_idx,
    output logic                           lb_full,
    output logic [lsq_pkg::LB_IDX_W-1:0]   lb_free_idx,
    // Load results
    output logic                           cdb_valid,
    output logic [lsq_pkg::XLEN-1:0]       cdb_value,
    output logic [lsq_pkg::PREG_IDX_W-1:0] cdb_preg,
    output logic [lsq_pkg::ROB_IDX_W-1:0]  cdb_rob_idx,
    output logic                           load_req_valid,
    output logic [lsq_pkg::XLEN-1:0]       load_req_addr,
    output logic [lsq_pkg::PREG_IDX_W-1:0] load_req_preg,
    output logic [lsq_pkg::ROB_IDX_W-1:0]  load_req_rob_idx
);

    import lsq_pkg::*;

    logic [SQ_IDX_W-1:0]   sq_head;
    sq_state_t             sq_state [SQ_DEPTH];
    logic [XLEN-1:0]       sq_addr [SQ_DEPTH];
    logic [XLEN-1:0]       sq_data [SQ_DEPTH];
    lb_state_t             lb_state [LB_DEPTH];
    logic [SQ_IDX_W-1:0]   lb_age [LB_DEPTH];
    logic [XLEN-1:0]       lb_addr [LB_DEPTH];
    logic [PREG_IDX_W-1:0] lb_preg [LB_DEPTH];
    logic [ROB_IDX_W-1:0]  lb_rob [LB_DEPTH];
    logic                  issue_valid;
    logic [LB_IDX_W-1:0]   issue_idx;

    store_queue u_store_queue (
        .clock, .reset,
        .store_alloc, .store_resolve_valid, .store_resolve_idx,
        .store_base, .store_offset, .store_value, .store_rob_idx,
        .store_retire,
        .sq_full, .sq_head_resolved, .sq_tail, .sq_head,
        .sq_state, .sq_addr, .sq_data,
        .store_req_valid, .store_req_addr, .store_req_data
    );

    load_buffer u_load_buffer (
        .clock, .reset,
        .load_alloc, .load_resolve_valid, .load_resolve_idx,
        .load_base, .load_offset, .load_dest_preg, .load_rob_idx,
        .sq_tail, .issue_valid, .issue_idx,
        .lb_full, .lb_free_idx,
        .lb_state, .lb_age, .lb_addr, .lb_preg, .lb_rob
    );

    load_order_check u_load_order_check (
        .sq_state, .sq_head,
        .lb_state, .lb_age,
        .issue_valid, .issue_idx
    );

    // Issued slot fields picked out of the load buffer arrays
    store_forward u_store_forward (
        .clock, .reset,
        .issue_valid,
        .issue_addr (lb_addr[issue_idx]),
        .issue_age  (lb_age[issue_idx]),
        .issue_preg (lb_preg[issue_idx]),
        .issue_rob  (lb_rob[issue_idx]),
        .sq_state, .sq_addr, .sq_data, .sq_head,
        .cdb_valid, .cdb_value, .cdb_preg, .cdb_rob_idx,
        .load_req_valid, .load_req_addr, .load_req_preg, .load_req_rob_idx
    );

endmodule

`default_nettype wire

// File: src/store_forward.sv
`timescale 1ns/1ns
`default_nettype none

module store_forward (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           issue_valid,
    input  logic [lsq_pkg::XLEN-1:0]       issue_addr,
    input  logic [lsq_pkg::SQ_IDX_W-1:0]   issue_age,
    input  logic [lsq_pkg::PREG_IDX_W-1:0] issue_preg,
    input  logic [lsq_pkg::ROB_IDX_W-1:0]  issue_rob,
    input  lsq_pkg::sq_state_t             sq_state [lsq_pkg::SQ_DEPTH],
    input  logic [lsq_pkg::XLEN-1:0]       sq_addr [lsq_pkg::SQ_DEPTH],
    input  logic [lsq_pkg::XLEN-1:0]       sq_data [lsq_pkg::SQ_DEPTH],
    input  logic [lsq_pkg::SQ_IDX_W-1:0]   sq_head,
    output logic                           cdb_valid,
    output logic [lsq_pkg::XLEN-1:0]       cdb_value,
    output logic [lsq_pkg::PREG_IDX_W-1:0] cdb_preg,
    output logic [lsq_pkg::ROB_IDX_W-1:0]  cdb_rob_idx,
    output logic                           load_req_valid,
    output logic [lsq_pkg::XLEN-1:0]       load_req_addr,
    output logic [lsq_pkg::PREG_IDX_W-1:0] load_req_preg,
    output logic [lsq_pkg::ROB_IDX_W-1:0]  load_req_rob_idx
);

    import lsq_pkg::*;

    logic                  ld_valid;
    logic [XLEN-1:0]       ld_addr;
    logic [SQ_IDX_W-1:0]   ld_age;
    logic [PREG_IDX_W-1:0] ld_preg;
    logic [ROB_IDX_W-1:0]  ld_rob;
    logic                  hit;
    logic [SQ_IDX_W-1:0]   hit_idx;

    // Issued load stage
    always_ff @(posedge clock) begin
        if (reset) begin
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            ld_addr <= issue_addr;
            ld_age <= issue_age;
            ld_preg <= issue_preg;
            ld_rob <= issue_rob;
        end
    end

    // Later matches overwrite earlier ones, so the youngest older store wins
    always_comb begin
        logic                in_range;
        logic [SQ_IDX_W-1:0] pos;
        in_range = 1'b1;
        hit = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            pos = sq_head + SQ_IDX_W'(i);
            if (pos == ld_age) begin
                in_range = 1'b0;
            end
            if (in_range && (sq_state[pos] == SQ_RESOLVED) && (sq_addr[pos] == ld_addr)) begin
                hit = 1'b1;
                hit_idx = pos;
            end
        end
    end

    ////////////////////////////////////////
    // CDB or cache, never both
    ////////////////////////////////////////

    assign cdb_valid = ld_valid && hit;
    assign cdb_value = sq_data[hit_idx];
    assign cdb_preg = ld_preg;
    assign cdb_rob_idx = ld_rob;

    assign load_req_valid = ld_valid && !hit;
    assign load_req_addr = ld_addr;
    assign load_req_preg = ld_preg;
    assign load_req_rob_idx = ld_rob;

endmodule

`default_nettype wire

// File: src/load_order_check.sv
`timescale 1ns/1ns
`default_nettype none

module load_order_check (
    input  lsq_pkg::sq_state_t           sq_state [lsq_pkg::SQ_DEPTH],
    input  logic [lsq_pkg::SQ_IDX_W-1:0] sq_head,
    input  lsq_pkg::lb_state_t           lb_state [lsq_pkg::LB_DEPTH],
    input  logic [lsq_pkg::SQ_IDX_W-1:0] lb_age [lsq_pkg::LB_DEPTH],
    output logic                         issue_valid,
    output logic [lsq_pkg::LB_IDX_W-1:0] issue_idx
);

    import lsq_pkg::*;

    logic [LB_DEPTH-1:0] blocked;
    logic [LB_DEPTH-1:0] issuable;

    ////////////////////////////////////////
    // Older-store scan per load slot
    ////////////////////////////////////////

    // Walk from head until the load's age, any pending store blocks it
    always_comb begin
        logic                in_range;
        logic [SQ_IDX_W-1:0] pos;
        in_range = 1'b0;
        pos = '0;
        for (int j = 0; j < LB_DEPTH; j++) begin
            blocked[j] = 1'b0;
            in_range = 1'b1;
            for (int i = 0; i < SQ_DEPTH; i++) begin
                pos = sq_head + SQ_IDX_W'(i);
                if (pos == lb_age[j]) begin
                    in_range = 1'b0;
                end
                if (in_range && (sq_state[pos] == SQ_PENDING)) begin
                    blocked[j] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int j = 0; j < LB_DEPTH; j++) begin
            issuable[j] = (lb_state[j] == LB_READY) && !blocked[j];
        end
    end

    // Fixed priority, lowest slot first
    always_comb begin
        issue_valid = |issuable;
        issue_idx = '0;
        for (int j = LB_DEPTH - 1; j >= 0; j--) begin
            if (issuable[j]) begin
                issue_idx = LB_IDX_W'(j);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/load_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module load_buffer (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           load_alloc,
    input  logic                           load_resolve_valid,
    input  logic [lsq_pkg::LB_IDX_W-1:0]   load_resolve_idx,
    input  logic [lsq_pkg::XLEN-1:0]       load_base,
    input  logic [lsq_pkg::XLEN-1:0]       load_offset,
    input  logic [lsq_pkg::PREG_IDX_W-1:0] load_dest_preg,
    input  logic [lsq_pkg::ROB_IDX_W-1:0]  load_rob_idx,
    input  logic [lsq_pkg::SQ_IDX_W-1:0]   sq_tail,
    input  logic                           issue_valid,
    input  logic [lsq_pkg::LB_IDX_W-1:0]   issue_idx,
    output logic                           lb_full,
    output logic [lsq_pkg::LB_IDX_W-1:0]   lb_free_idx,
    output lsq_pkg::lb_state_t             lb_state [lsq_pkg::LB_DEPTH],
    output logic [lsq_pkg::SQ_IDX_W-1:0]   lb_age [lsq_pkg::LB_DEPTH],
    output logic [lsq_pkg::XLEN-1:0]       lb_addr [lsq_pkg::LB_DEPTH],
    output logic [lsq_pkg::PREG_IDX_W-1:0] lb_preg [lsq_pkg::LB_DEPTH],
    output logic [lsq_pkg::ROB_IDX_W-1:0]  lb_rob [lsq_pkg::LB_DEPTH]
);

    import lsq_pkg::*;

    logic resolve_ok;

    assign resolve_ok = load_resolve_valid && (lb_state[load_resolve_idx] == LB_WAITING);

    // Lowest free slot wins, so scan downward
    always_comb begin
        lb_full = 1'b1;
        lb_free_idx = '0;
        for (int j = LB_DEPTH - 1; j >= 0; j--) begin
            if (lb_state[j] == LB_FREE) begin
                lb_full = 1'b0;
                lb_free_idx = LB_IDX_W'(j);
            end
        end
    end

    ////////////////////////////////////////
    // Slot state
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < LB_DEPTH; j++) begin
                lb_state[j] <= LB_FREE;
            end
        end else begin
            if (load_alloc) begin
                lb_state[lb_free_idx] <= LB_WAITING;
            end
            if (resolve_ok) begin
                lb_state[load_resolve_idx] <= LB_READY;
            end
            // Issued slot leaves the buffer
            if (issue_valid) begin
                lb_state[issue_idx] <= LB_FREE;
            end
        end
    end

    // Age is the store tail seen at allocation
    always_ff @(posedge clock) begin
        if (load_alloc) begin
            lb_age[lb_free_idx] <= sq_tail;
        end
        if (resolve_ok) begin
            lb_addr[load_resolve_idx] <= load_base + load_offset;
            lb_preg[load_resolve_idx] <= load_dest_preg;
            lb_rob[load_resolve_idx] <= load_rob_idx;
        end
    end

endmodule

`default_nettype wire

// File: src/store_queue.sv
`timescale 1ns/1ns
`default_nettype none

module store_queue (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          store_alloc,
    input  logic                          store_resolve_valid,
    input  logic [lsq_pkg::SQ_IDX_W-1:0]  store_resolve_idx,
    input  logic [lsq_pkg::XLEN-1:0]      store_base,
    input  logic [lsq_pkg::XLEN-1:0]      store_offset,
    input  logic [lsq_pkg::XLEN-1:0]      store_value,
    input  logic [lsq_pkg::ROB_IDX_W-1:0] store_rob_idx,
    input  logic                          store_retire,
    output logic                          sq_full,
    output logic                          sq_head_resolved,
    output logic [lsq_pkg::SQ_IDX_W-1:0]  sq_tail,
    output logic [lsq_pkg::SQ_IDX_W-1:0]  sq_head,
    output lsq_pkg::sq_state_t            sq_state [lsq_pkg::SQ_DEPTH],
    output logic [lsq_pkg::XLEN-1:0]      sq_addr [lsq_pkg::SQ_DEPTH],
    output logic [lsq_pkg::XLEN-1:0]      sq_data [lsq_pkg::SQ_DEPTH],
    output logic                          store_req_valid,
    output logic [lsq_pkg::XLEN-1:0]      store_req_addr,
    output logic [lsq_pkg::XLEN-1:0]      store_req_data
);

    import lsq_pkg::*;

    logic [SQ_IDX_W-1:0]  fill_count;
    logic                 resolve_ok;
    logic                 retire_ok;

    ////////////////////////////////////////
    // Occupancy and head status
    ////////////////////////////////////////

    // Pointer distance wraps with the index width
    assign fill_count = sq_tail - sq_head;
    assign sq_full = (fill_count == SQ_IDX_W'(SQ_DEPTH - 1));

    assign sq_head_resolved = (sq_state[sq_head] == SQ_RESOLVED);
    assign resolve_ok = store_resolve_valid && (sq_state[store_resolve_idx] == SQ_PENDING);
    assign retire_ok = store_retire && sq_head_resolved;

    // Cache store request straight from the head entry
    assign store_req_valid = retire_ok;
    assign store_req_addr = sq_addr[sq_head];
    assign store_req_data = sq_data[sq_head];

    ////////////////////////////////////////
    // Entry state and pointers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            sq_head <= '0;
            sq_tail <= '0;
            for (int i = 0; i < SQ_DEPTH; i++) begin
                sq_state[i] <= SQ_FREE;
            end
        end else begin
            if (store_alloc) begin
                sq_state[sq_tail] <= SQ_PENDING;
                sq_tail <= sq_tail + 1'b1;
            end
            if (resolve_ok) begin
                sq_state[store_resolve_idx] <= SQ_RESOLVED;
            end
            // Retired entry goes back to free and the head moves on
            if (retire_ok) begin
                sq_state[sq_head] <= SQ_FREE;
                sq_head <= sq_head + 1'b1;
            end
        end
    end

    // Address and data written at resolve
    always_ff @(posedge clock) begin
        if (resolve_ok) begin
            sq_addr[store_resolve_idx] <= store_base + store_offset;
            sq_data[store_resolve_idx] <= store_value;
        end
    end

endmodule

`default_nettype wire

// File: src/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int XLEN = 32;

    // Ring of 8 entries, at most 7 in use so tail never catches head
    localparam int SQ_DEPTH = 8;
    localparam int SQ_IDX_W = 3;

    localparam int LB_DEPTH = 4;
    localparam int LB_IDX_W = 2;

    localparam int PREG_IDX_W = 6;
    localparam int ROB_IDX_W = 5;

    ////////////////////////////////////////
    // Entry states
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        SQ_FREE = 2'd0,
        SQ_PENDING = 2'd1,    // allocated, address not known yet
        SQ_RESOLVED = 2'd2
    } sq_state_t;

    typedef enum logic [1:0] {
        LB_FREE = 2'd0,
        LB_WAITING = 2'd1,
        LB_READY = 2'd2       // resolved, waiting to issue
    } lb_state_t;

endpackage

`default_nettype wire
